// File: run.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert --top-module tb_top -f tb.f -o tb_sim \
  && ./obj_dir/tb_sim 2>&1 | tee sim.log \
  || { echo "Build or simulation ended with an error"; exit 1; }

grep -q "Test failed" sim.log \
  && { echo "Simulation FAILED"; exit 1; } \
  || { echo "Simulation PASSED"; exit 0; }

// File: source/bus_memory.sv
`timescale 1ns/100ps
`include "ss_cfg.svh"

module bus_memory #(
  parameter int                   MEM_DATA_WIDTH = 4,
  parameter int                   MEM_ADDR_WIDTH = 7,
  parameter ss_bus_pkg::ss_addr_t ADDRESS_MIN    = 8'h10,
  parameter ss_bus_pkg::ss_addr_t ADDRESS_MAX    = 8'h18
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  ss_bus_pkg::ss_data_t      bus_in,
  input  ss_bus_pkg::ss_addr_t      bus_addr,
  input  logic                      bus_wren,
  output ss_bus_pkg::ss_data_t      bus_out,
  output logic [MEM_ADDR_WIDTH-1:0] mem_addr,
  input  logic [MEM_DATA_WIDTH-1:0] mem_current_data,
  output logic [MEM_DATA_WIDTH-1:0] mem_new_data,
  output logic                      mem_wren,
  output logic                      mem_active
);

  localparam int WORDS_PER_BUS = `SS_DATA_WIDTH / MEM_DATA_WIDTH;
  localparam int OFFSET_WIDTH  = $clog2(WORDS_PER_BUS);
  localparam int ENTRY_WIDTH   = MEM_ADDR_WIDTH - OFFSET_WIDTH;
  localparam logic [OFFSET_WIDTH-1:0] LAST_OFFSET = OFFSET_WIDTH'(WORDS_PER_BUS - 1);

  ss_mem_pkg::bridge_state_t state;
  ss_bus_pkg::ss_addr_t      rel_addr;
  ss_bus_pkg::ss_addr_t      last_addr;
  ss_bus_pkg::ss_data_t      buffer;
  logic [OFFSET_WIDTH-1:0]   word_offset;
  logic [MEM_DATA_WIDTH-1:0] top_word;
  logic                      is_writing;
  logic                      write_en;
  logic                      start;

  assign mem_active = (bus_addr >= ADDRESS_MIN) && (bus_addr < ADDRESS_MAX);
  assign rel_addr   = bus_addr - ADDRESS_MIN;

  // Entry bits select the bus word, offset bits select the narrow word inside it
  assign mem_addr = {rel_addr[ENTRY_WIDTH-1:0], word_offset};

  // A transfer starts only when the address in range differs from the last one served
  assign start = mem_active && (state == ss_mem_pkg::BRIDGE_IDLE) && (bus_addr != last_addr);

  // The lowest buffer word is always the one being written
  assign mem_new_data = buffer[MEM_DATA_WIDTH-1:0];

  // Gating with mem_active keeps a stale strobe off the RAM when the host moves away
  assign mem_wren = write_en & mem_active;

  // A write rotates its own words so the buffer ends up holding the written value
  // A read brings in the RAM word at the top
  assign top_word = is_writing ? buffer[MEM_DATA_WIDTH-1:0] : mem_current_data;

  assign bus_out = mem_active ? buffer : '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= ss_mem_pkg::BRIDGE_IDLE;
      word_offset <= '0;
      // ADDRESS_MAX lies outside the region, so it never matches a live address
      last_addr   <= ADDRESS_MAX;
      is_writing  <= 1'b0;
      write_en    <= 1'b0;
    end else if (!mem_active) begin
      // Leaving the region aborts any transfer and forgets the last address
      state       <= ss_mem_pkg::BRIDGE_IDLE;
      word_offset <= '0;
      last_addr   <= ADDRESS_MAX;
      write_en    <= 1'b0;
    end else begin
      case (state)
        ss_mem_pkg::BRIDGE_IDLE: begin
          if (start) begin
            state      <= ss_mem_pkg::BRIDGE_XFER;
            is_writing <= bus_wren;
            write_en   <= bus_wren;
            last_addr  <= bus_addr;
          end
        end
        ss_mem_pkg::BRIDGE_XFER: begin
          word_offset <= word_offset + 1'b1;
          // Both directions finish after the word at the last offset
          if (word_offset == LAST_OFFSET) begin
            state       <= ss_mem_pkg::BRIDGE_IDLE;
            write_en    <= 1'b0;
            word_offset <= '0;
          end
        end
        default: begin
          state <= ss_mem_pkg::BRIDGE_IDLE;
        end
      endcase
    end
  end

  // Shift buffer shared by reads and writes
  always_ff @(posedge clk) begin
    if (start && bus_wren) begin
      buffer <= bus_in;
    end else if (mem_active && (state == ss_mem_pkg::BRIDGE_XFER)) begin
      buffer <= {top_word, buffer[`SS_DATA_WIDTH-1:MEM_DATA_WIDTH]};
    end
  end

endmodule

// File: source/ss_bus_capture.sv
`timescale 1ns/100ps

module ss_bus_capture (
  input  logic                 clk,
  input  logic                 arst_n,
  input  ss_bus_pkg::ss_addr_t host_addr,
  input  ss_bus_pkg::ss_data_t host_data,
  input  logic                 host_wren,
  input  logic                 host_reset,
  output ss_bus_pkg::ss_addr_t bus_addr,
  output ss_bus_pkg::ss_data_t bus_in,
  output logic                 bus_wren,
  output logic                 bus_reset
);

  // Previous host_reset level, used to find its rising edge
  logic host_reset_q;

  // Control levels from the host, one register stage into the clock domain
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bus_addr     <= '0;
      bus_wren     <= 1'b0;
      host_reset_q <= 1'b0;
      bus_reset    <= 1'b0;
    end else begin
      bus_addr     <= host_addr;
      bus_wren     <= host_wren;
      host_reset_q <= host_reset;
      // A held restore level still yields a single pulse
      bus_reset    <= host_reset & ~host_reset_q;
    end
  end

  // Write data lines up with the address capture
  always_ff @(posedge clk) begin
    bus_in <= host_data;
  end

endmodule

// File: source/ss_bus_pkg.sv
`include "ss_cfg.svh"

// Types seen on the host side of the subsystem
package ss_bus_pkg;

  // One byte-wide bus address covering every region
  typedef logic [`SS_BUS_WIDTH-1:0] ss_addr_t;

  // One full bus word as moved by the host in a single access
  typedef logic [`SS_DATA_WIDTH-1:0] ss_data_t;

endpackage

// File: source/ss_cfg.svh
`ifndef SS_CFG_SVH
`define SS_CFG_SVH

// Host bus geometry
`define SS_BUS_WIDTH 8
`define SS_DATA_WIDTH 64

// Control register region, upper bound exclusive
`define REG_ADDR_MIN 8'h00
`define REG_ADDR_MAX 8'h04

// Nibble RAM region and its memory word width
`define NIB_ADDR_MIN 8'h10
`define NIB_ADDR_MAX 8'h18
`define NIB_WORD_WIDTH 4

// Halfword RAM region and its memory word width
`define HW_ADDR_MIN 8'h20
`define HW_ADDR_MAX 8'h24
`define HW_WORD_WIDTH 16

// Values loaded on reset and on a host restore
`define REG_DEFAULT_0 64'h0000_0000_0000_0001
`define REG_DEFAULT_1 64'h0123_4567_89AB_CDEF
`define REG_DEFAULT_2 64'hFFFF_0000_FFFF_0000
`define REG_DEFAULT_3 64'hDEAD_BEEF_CAFE_F00D

`endif

// File: source/ss_mem_pkg.sv
`include "ss_cfg.svh"

// Types seen on the memory side of the bridges
package ss_mem_pkg;

  // Bridge sequencing, idle until a new in-range address shows up
  typedef enum logic {
    BRIDGE_IDLE,
    BRIDGE_XFER
  } bridge_state_t;

  // Narrow word stored in the nibble RAM
  typedef logic [`NIB_WORD_WIDTH-1:0] nib_word_t;

  // Word stored in the halfword RAM
  typedef logic [`HW_WORD_WIDTH-1:0] hw_word_t;

endpackage

// File: source/ss_ram.sv
`timescale 1ns/100ps

module ss_ram #(
  parameter int WORD_WIDTH = 4,
  parameter int ADDR_WIDTH = 7
) (
  input  logic                  clk,
  input  logic [ADDR_WIDTH-1:0] addr,
  input  logic [WORD_WIDTH-1:0] wr_data,
  input  logic                  wren,
  output logic [WORD_WIDTH-1:0] rd_data
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  // Storage array, contents undefined until written
  logic [WORD_WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wren) begin
      mem[addr] <= wr_data;
    end
  end

  // The bridge expects the word for addr within the same cycle
  assign rd_data = mem[addr];

endmodule

// File: source/ss_readback.sv
`timescale 1ns/100ps

module ss_readback (
  input  logic                 clk,
  input  logic                 arst_n,
  input  ss_bus_pkg::ss_data_t reg_out,
  input  logic                 reg_active,
  input  ss_bus_pkg::ss_data_t nib_out,
  input  logic                 nib_active,
  input  ss_bus_pkg::ss_data_t hw_out,
  input  logic                 hw_active,
  output ss_bus_pkg::ss_data_t rd_data,
  output logic                 bus_err
);

  logic any_active;

  // Regions never overlap, so at most one of these is set
  assign any_active = reg_active | nib_active | hw_active;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_data <= '0;
      bus_err <= 1'b0;
    end else begin
      // Each region drives zero while unselected, so an OR acts as the mux
      rd_data <= reg_out | nib_out | hw_out;
      // Nothing claimed the address
      bus_err <= ~any_active;
    end
  end

endmodule

// File: source/ss_reg_bank.sv
`timescale 1ns/100ps
`include "ss_cfg.svh"

module ss_reg_bank (
  input  logic                 clk,
  input  logic                 arst_n,
  input  ss_bus_pkg::ss_addr_t bus_addr,
  input  ss_bus_pkg::ss_data_t bus_in,
  input  logic                 bus_wren,
  input  logic                 bus_reset,
  output ss_bus_pkg::ss_data_t bus_out,
  output logic                 reg_active
);

  localparam int REG_COUNT = `REG_ADDR_MAX - `REG_ADDR_MIN;
  localparam int SEL_WIDTH = $clog2(REG_COUNT);

  // Default value of each register, indexed like the bank itself
  localparam ss_bus_pkg::ss_data_t REG_DEFAULTS [REG_COUNT] = '{
    `REG_DEFAULT_0,
    `REG_DEFAULT_1,
    `REG_DEFAULT_2,
    `REG_DEFAULT_3
  };

  ss_bus_pkg::ss_data_t regs [REG_COUNT];
  ss_bus_pkg::ss_addr_t rel_addr;
  logic [SEL_WIDTH-1:0] sel;

  assign reg_active = (bus_addr >= `REG_ADDR_MIN) && (bus_addr < `REG_ADDR_MAX);

  // Region-relative index, only meaningful while the region is selected
  assign rel_addr = bus_addr - `REG_ADDR_MIN;
  assign sel      = rel_addr[SEL_WIDTH-1:0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= REG_DEFAULTS[i];
      end
    end else if (reg_active) begin
      // A restore wins over a write seen in the same cycle
      if (bus_reset) begin
        regs[sel] <= REG_DEFAULTS[sel];
      end else if (bus_wren) begin
        regs[sel] <= bus_in;
      end
    end
  end

  // Quiet outside the region so the readback can OR all regions together
  assign bus_out = reg_active ? regs[sel] : '0;

endmodule

// File: source/ss_top.sv
`timescale 1ns/100ps
`include "ss_cfg.svh"

module ss_top (
  input  logic                 clk,
  input  logic                 arst_n,
  input  ss_bus_pkg::ss_addr_t host_addr,
  input  ss_bus_pkg::ss_data_t host_data,
  input  logic                 host_wren,
  input  logic                 host_reset,
  output ss_bus_pkg::ss_data_t rd_data,
  output logic                 bus_err
);

  // Entry bits come from the region size, offset bits from words per bus word
  localparam int NIB_MEM_AW = $clog2(`NIB_ADDR_MAX - `NIB_ADDR_MIN)
                            + $clog2(`SS_DATA_WIDTH / `NIB_WORD_WIDTH);
  localparam int HW_MEM_AW  = $clog2(`HW_ADDR_MAX - `HW_ADDR_MIN)
                            + $clog2(`SS_DATA_WIDTH / `HW_WORD_WIDTH);

  ss_bus_pkg::ss_addr_t bus_addr;
  ss_bus_pkg::ss_data_t bus_in;
  logic                 bus_wren;
  logic                 bus_reset;

  ss_bus_pkg::ss_data_t reg_out;
  logic                 reg_active;

  ss_bus_pkg::ss_data_t  nib_out;
  logic                  nib_active;
  logic [NIB_MEM_AW-1:0] nib_mem_addr;
  ss_mem_pkg::nib_word_t nib_wr_data;
  ss_mem_pkg::nib_word_t nib_rd_data;
  logic                  nib_mem_wren;

  ss_bus_pkg::ss_data_t hw_out;
  logic                 hw_active;
  logic [HW_MEM_AW-1:0] hw_mem_addr;
  ss_mem_pkg::hw_word_t hw_wr_data;
  ss_mem_pkg::hw_word_t hw_rd_data;
  logic                 hw_mem_wren;

  ss_bus_capture u_capture (
    .clk        (clk),
    .arst_n     (arst_n),
    .host_addr  (host_addr),
    .host_data  (host_data),
    .host_wren  (host_wren),
    .host_reset (host_reset),
    .bus_addr   (bus_addr),
    .bus_in     (bus_in),
    .bus_wren   (bus_wren),
    .bus_reset  (bus_reset)
  );

  ss_reg_bank u_reg_bank (
    .clk        (clk),
    .arst_n     (arst_n),
    .bus_addr   (bus_addr),
    .bus_in     (bus_in),
    .bus_wren   (bus_wren),
    .bus_reset  (bus_reset),
    .bus_out    (reg_out),
    .reg_active (reg_active)
  );

  // Nibble RAM takes sixteen memory words per bus word
  bus_memory #(
    .MEM_DATA_WIDTH (`NIB_WORD_WIDTH),
    .MEM_ADDR_WIDTH (NIB_MEM_AW),
    .ADDRESS_MIN    (`NIB_ADDR_MIN),
    .ADDRESS_MAX    (`NIB_ADDR_MAX)
  ) u_nib_bridge (
    .clk              (clk),
    .arst_n           (arst_n),
    .bus_in           (bus_in),
    .bus_addr         (bus_addr),
    .bus_wren         (bus_wren),
    .bus_out          (nib_out),
    .mem_addr         (nib_mem_addr),
    .mem_current_data (nib_rd_data),
    .mem_new_data     (nib_wr_data),
    .mem_wren         (nib_mem_wren),
    .mem_active       (nib_active)
  );

  ss_ram #(
    .WORD_WIDTH (`NIB_WORD_WIDTH),
    .ADDR_WIDTH (NIB_MEM_AW)
  ) u_nib_ram (
    .clk     (clk),
    .addr    (nib_mem_addr),
    .wr_data (nib_wr_data),
    .wren    (nib_mem_wren),
    .rd_data (nib_rd_data)
  );

  // Halfword RAM takes four memory words per bus word
  bus_memory #(
    .MEM_DATA_WIDTH (`HW_WORD_WIDTH),
    .MEM_ADDR_WIDTH (HW_MEM_AW),
    .ADDRESS_MIN    (`HW_ADDR_MIN),
    .ADDRESS_MAX    (`HW_ADDR_MAX)
  ) u_hw_bridge (
    .clk              (clk),
    .arst_n           (arst_n),
    .bus_in           (bus_in),
    .bus_addr         (bus_addr),
    .bus_wren         (bus_wren),
    .bus_out          (hw_out),
    .mem_addr         (hw_mem_addr),
    .mem_current_data (hw_rd_data),
    .mem_new_data     (hw_wr_data),
    .mem_wren         (hw_mem_wren),
    .mem_active       (hw_active)
  );

  ss_ram #(
    .WORD_WIDTH (`HW_WORD_WIDTH),
    .ADDR_WIDTH (HW_MEM_AW)
  ) u_hw_ram (
    .clk     (clk),
    .addr    (hw_mem_addr),
    .wr_data (hw_wr_data),
    .wren    (hw_mem_wren),
    .rd_data (hw_rd_data)
  );

  ss_readback u_readback (
    .clk        (clk),
    .arst_n     (arst_n),
    .reg_out    (reg_out),
    .reg_active (reg_active),
    .nib_out    (nib_out),
    .nib_active (nib_active),
    .hw_out     (hw_out),
    .hw_active  (hw_active),
    .rd_data    (rd_data),
    .bus_err    (bus_err)
  );

endmodule

// File: tb.f
+incdir+source
source/ss_bus_pkg.sv
source/ss_mem_pkg.sv
source/ss_bus_capture.sv
source/ss_reg_bank.sv
source/bus_memory.sv
source/ss_ram.sv
source/ss_readback.sv
source/ss_top.sv
verif/tb_clock.sv
verif/ss_assert.sv
verif/tb_top.sv

// File: verif/ss_assert.sv
`timescale 1ns/100ps
`include "ss_cfg.svh"

module ss_assert (
  input logic                 clk,
  input logic                 arst_n,
  input ss_bus_pkg::ss_addr_t bus_addr,
  input logic                 nib_active,
  input logic                 hw_active,
  input logic                 nib_mem_wren,
  input logic                 hw_mem_wren,
  input ss_bus_pkg::ss_data_t rd_data,
  input logic                 bus_err
);

  logic addr_mapped;

  // Address map built straight from the region bounds, apart from the region decoders
  assign addr_mapped = ((bus_addr >= `REG_ADDR_MIN) && (bus_addr < `REG_ADDR_MAX))
                    || ((bus_addr >= `NIB_ADDR_MIN) && (bus_addr < `NIB_ADDR_MAX))
                    || ((bus_addr >= `HW_ADDR_MIN) && (bus_addr < `HW_ADDR_MAX));

  // A bridge may only strobe its RAM while the bus address sits in its region
  nib_wren_in_region: assert property (@(posedge clk) disable iff (!arst_n)
    nib_mem_wren |-> nib_active)
    else $error("Nibble RAM write strobe seen outside the nibble region");

  hw_wren_in_region: assert property (@(posedge clk) disable iff (!arst_n)
    hw_mem_wren |-> hw_active)
    else $error("Halfword RAM write strobe seen outside the halfword region");

  // bus_err is registered, so a mapped address clears it one cycle later
  err_vs_map: assert property (@(posedge clk) disable iff (!arst_n)
    addr_mapped |=> !bus_err)
    else $error("bus_err raised although the address lies in a region");

  // The error flag and the read data share one register stage
  err_zero_data: assert property (@(posedge clk) disable iff (!arst_n)
    bus_err |-> (rd_data == '0))
    else $error("rd_data not zero while bus_err is high");

endmodule

bind ss_top ss_assert u_assert (
  .clk          (clk),
  .arst_n       (arst_n),
  .bus_addr     (bus_addr),
  .nib_active   (nib_active),
  .hw_active    (hw_active),
  .nib_mem_wren (nib_mem_wren),
  .hw_mem_wren  (hw_mem_wren),
  .rd_data      (rd_data),
  .bus_err      (bus_err)
);

// File: verif/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
  output logic clk
);

  // Free-running clock with a 20 ns period, low at time zero
  initial begin
    clk = 1'b0;
  end

  always #10 clk = ~clk;

endmodule

// File: verif/tb_top.sv
`timescale 1ns/100ps
`include "ss_cfg.svh"

module tb_top;

  // 52 accesses of close to 30 cycles each, roughly doubled for margin
  localparam int CYCLE_LIMIT = 3000;
  // Worst case from address change to valid rd_data is 20 cycles
  localparam int ACCESS_WAIT = 24;
  localparam ss_bus_pkg::ss_addr_t PARK_ADDR = 8'hF0;

  logic                 clk;
  logic                 arst_n;
  ss_bus_pkg::ss_addr_t host_addr;
  ss_bus_pkg::ss_data_t host_data;
  logic                 host_wren;
  logic                 host_reset;
  ss_bus_pkg::ss_data_t rd_data;
  logic                 bus_err;

  logic [15:0] lfsr_state;
  int          cycle_count = 0;

  // Expected contents, built up from the writes made so far
  ss_bus_pkg::ss_data_t reg_model [4];
  ss_bus_pkg::ss_data_t nib_model [8];
  ss_bus_pkg::ss_data_t hw_model [4];

  tb_clock u_clock (
    .clk (clk)
  );

  ss_top dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .host_addr  (host_addr),
    .host_data  (host_data),
    .host_wren  (host_wren),
    .host_reset (host_reset),
    .rd_data    (rd_data),
    .bus_err    (bus_err)
  );

  // Ends a hung run; counts every rising edge from time zero
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  // 16-bit Galois LFSR, polynomial x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 16'hB400;
    end
    return next;
  endfunction

  // One LFSR step per bit, so a bus word costs 64 steps
  task automatic draw_random(output ss_bus_pkg::ss_data_t value);
    value = '0;
    for (int i = 0; i < 64; i++) begin
      value      = {value[62:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic check_value(input string name, input ss_bus_pkg::ss_data_t actual,
                             input ss_bus_pkg::ss_data_t expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("Test failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic wait_cycles(input int count);
    repeat (count) @(negedge clk);
  endtask

  // Leaving every region makes each bridge forget its last address
  task automatic park_address();
    @(negedge clk);
    host_addr = PARK_ADDR;
    host_wren = 1'b0;
    wait_cycles(3);
  endtask

  task automatic bus_write(input ss_bus_pkg::ss_addr_t addr, input ss_bus_pkg::ss_data_t data);
    @(negedge clk);
    host_addr = addr;
    host_data = data;
    host_wren = 1'b1;
    wait_cycles(ACCESS_WAIT);
    park_address();
  endtask

  // Reads one address and compares both the data and the error flag
  task automatic read_check(input ss_bus_pkg::ss_addr_t addr,
                            input ss_bus_pkg::ss_data_t expected, input logic expected_err);
    ss_bus_pkg::ss_data_t data;
    logic                 err;
    @(negedge clk);
    host_addr = addr;
    host_wren = 1'b0;
    wait_cycles(ACCESS_WAIT);
    data = rd_data;
    err  = bus_err;
    park_address();
    check_value($sformatf("rd_data @ 0x%h", addr), data, expected);
    check_value($sformatf("bus_err @ 0x%h", addr), 64'(err), 64'(expected_err));
  endtask

  // Holds the address, then raises host_reset long enough for one restore pulse
  task automatic restore_register(input ss_bus_pkg::ss_addr_t addr);
    @(negedge clk);
    host_addr = addr;
    host_wren = 1'b0;
    wait_cycles(4);
    host_reset = 1'b1;
    wait_cycles(3);
    host_reset = 1'b0;
    wait_cycles(2);
    park_address();
  endtask

  task automatic reset_defaults_read();
    for (int i = 0; i < 4; i++) begin
      read_check(8'(`REG_ADDR_MIN + i), reg_model[i], 1'b0);
    end
  endtask

  task automatic register_round_trip();
    ss_bus_pkg::ss_data_t value;
    for (int i = 0; i < 4; i++) begin
      draw_random(value);
      bus_write(8'(`REG_ADDR_MIN + i), value);
      reg_model[i] = value;
    end
    for (int i = 0; i < 4; i++) begin
      read_check(8'(`REG_ADDR_MIN + i), reg_model[i], 1'b0);
    end
    // Only register 2 goes back to its default
    restore_register(8'(`REG_ADDR_MIN + 2));
    reg_model[2] = `REG_DEFAULT_2;
    for (int i = 0; i < 4; i++) begin
      read_check(8'(`REG_ADDR_MIN + i), reg_model[i], 1'b0);
    end
  endtask

  task automatic nibble_ram_check();
    for (int i = 7; i >= 0; i--) begin
      read_check(8'(`NIB_ADDR_MIN + i), nib_model[i], 1'b0);
    end
  endtask

  task automatic nibble_ram_round_trip();
    ss_bus_pkg::ss_data_t value;
    for (int i = 0; i < 8; i++) begin
      draw_random(value);
      bus_write(8'(`NIB_ADDR_MIN + i), value);
      nib_model[i] = value;
    end
    nibble_ram_check();
  endtask

  task automatic halfword_ram_round_trip();
    ss_bus_pkg::ss_data_t value;
    for (int i = 0; i < 4; i++) begin
      draw_random(value);
      bus_write(8'(`HW_ADDR_MIN + i), value);
      hw_model[i] = value;
    end
    for (int i = 3; i >= 0; i--) begin
      read_check(8'(`HW_ADDR_MIN + i), hw_model[i], 1'b0);
    end
    // Halfword traffic must leave the nibble RAM untouched
    nibble_ram_check();
  endtask

  task automatic unmapped_address_errors();
    read_check(PARK_ADDR, '0, 1'b1);
    read_check(8'(`NIB_ADDR_MAX), '0, 1'b1);
    read_check(8'(`NIB_ADDR_MIN), nib_model[0], 1'b0);
  endtask

  initial begin
    arst_n         = 1'b0;
    host_addr      = PARK_ADDR;
    host_data      = '0;
    host_wren      = 1'b0;
    host_reset     = 1'b0;
    lfsr_state     = 16'd42;
    reg_model[0]   = `REG_DEFAULT_0;
    reg_model[1]   = `REG_DEFAULT_1;
    reg_model[2]   = `REG_DEFAULT_2;
    reg_model[3]   = `REG_DEFAULT_3;
    repeat (3) @(negedge clk);
    arst_n = 1'b1;

    reset_defaults_read();
    register_round_trip();
    nibble_ram_round_trip();
    halfword_ram_round_trip();
    unmapped_address_errors();

    $display("Test completed successfully");
    $finish;
  end

endmodule
